// File: fm_slot_pkg.sv
package fm_slot_pkg;

	// sequencer geometry
	localparam int NUM_CH = 6;
	localparam int NUM_SLOTS = 24;
	localparam int CH_W = 3;
	localparam int OP_W = 2;
	localparam int SLOT_W = 5;

	// operator code advances after this channel
	localparam logic [CH_W-1:0] LAST_CH = 3'd6;

	// field widths
	localparam int FNUM_W = 11;
	localparam int BLOCK_W = 3;
	localparam int MUL_W = 4;
	localparam int TL_W = 7;
	localparam int PHASE_W = 20;

	// stored words: key, mul, tl per slot
	localparam int OP_WORD_W = 1 + MUL_W + TL_W;
	// latch (block, fnum high), block, fnum, fb, alg, rl per channel
	localparam int CH_WORD_W = 2 * BLOCK_W + (FNUM_W - 8) + FNUM_W + 8;

	// channel codes skip 3 and 7
	function automatic logic [CH_W-1:0] next_ch(input logic [CH_W-1:0] ch);
		return (ch[1:0] == 2'b10) ? ch + 3'd2 : ch + 3'd1;
	endfunction

	function automatic logic [OP_W-1:0] next_op(
		input logic [CH_W-1:0] ch,
		input logic [OP_W-1:0] op
	);
		return (ch == LAST_CH) ? op + 2'd1 : op;
	endfunction

	// dense 0..23 index of a slot
	function automatic logic [SLOT_W-1:0] slot_idx(
		input logic [CH_W-1:0] ch,
		input logic [OP_W-1:0] op
	);
		logic [SLOT_W-1:0] ch_pos;
		ch_pos = ch[2] ? SLOT_W'(ch) - SLOT_W'(1) : SLOT_W'(ch);
		return SLOT_W'(op) * SLOT_W'(NUM_CH) + ch_pos;
	endfunction

endpackage

// File: fm_reg_pkg.sv
package fm_reg_pkg;

	// register address map, per-channel registers add the channel offset
	localparam logic [7:0] ADDR_KEYON = 8'h28;
	localparam logic [7:0] ADDR_MUL = 8'h30;
	localparam logic [7:0] ADDR_TL = 8'h40;
	localparam logic [7:0] ADDR_FNLO = 8'hA0;
	localparam logic [7:0] ADDR_FNHI = 8'hA4;
	localparam logic [7:0] ADDR_FBALG = 8'hB0;
	localparam logic [7:0] ADDR_PAN = 8'hB4;

	// also the bit order of the update strobe bus
	typedef enum logic [2:0] {
		KEYON,
		MUL,
		TL,
		FNLO,
		FNHI,
		FBALG,
		PAN
	} reg_class_e;

	localparam int NUM_CLASSES = 7;

	typedef union packed {
		// operator registers
		union packed {
			struct packed {
				logic [3:0] mask;
				logic       rsv;
				logic [2:0] ch;
			} kon;
			struct packed {
				logic       rsv;
				logic [6:0] tl;
			} lvl;
			struct packed {
				logic [3:0] rsv;
				logic [3:0] mul;
			} mult;
		} op_view;
		// channel registers
		union packed {
			struct packed {
				logic [1:0] rl;
				logic [5:0] rsv;
			} pan;
			struct packed {
				logic [1:0] rsv;
				logic [2:0] block;
				logic [2:0] fnhi;
			} fhi;
			struct packed {
				logic [1:0] rsv;
				logic [2:0] fb;
				logic [2:0] alg;
			} fba;
		} ch_view;
	} reg_data_u;

endpackage

// File: fm_write_decoder.sv
`timescale 1ns/1ps

module fm_write_decoder (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               wr,
	input  logic                               part,
	input  logic [7:0]                         addr,
	input  logic [7:0]                         din,
	input  logic                               busy,
	output logic [fm_reg_pkg::NUM_CLASSES-1:0] up,
	output logic [fm_slot_pkg::CH_W-1:0]       up_ch,
	output logic [fm_slot_pkg::OP_W-1:0]       up_op,
	output fm_reg_pkg::reg_data_u              up_data
);
	import fm_slot_pkg::*;
	import fm_reg_pkg::*;

	reg_data_u       d;
	reg_class_e      cls;
	logic            valid;
	logic            take;
	logic [CH_W-1:0] ch_n;
	logic [OP_W-1:0] op_n;

	assign d = din;
	assign take = wr && !busy;

	always_comb begin
		cls = KEYON;
		valid = 1'b0;
		ch_n = {part, addr[1:0]};
		op_n = '0;
		if (addr == ADDR_KEYON) begin
			// channel comes from the data byte
			valid = d.op_view.kon.ch[1:0] != 2'b11;
			ch_n = d.op_view.kon.ch;
		end else if (addr[1:0] != 2'b11) begin
			valid = 1'b1;
			if (addr[7:4] == ADDR_MUL[7:4]) begin
				cls = MUL;
				op_n = addr[3:2];
			end else if (addr[7:4] == ADDR_TL[7:4]) begin
				cls = TL;
				op_n = addr[3:2];
			end else if (addr[7:2] == ADDR_FNLO[7:2]) begin
				cls = FNLO;
			end else if (addr[7:2] == ADDR_FNHI[7:2]) begin
				cls = FNHI;
			end else if (addr[7:2] == ADDR_FBALG[7:2]) begin
				cls = FBALG;
			end else if (addr[7:2] == ADDR_PAN[7:2]) begin
				cls = PAN;
			end else begin
				valid = 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			up <= '0;
		end else begin
			up <= (take && valid) ? NUM_CLASSES'(1) << cls : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			up_ch <= ch_n;
			up_op <= op_n;
			up_data <= d;
		end
	end

	// an update strobe lasts one clock
	a_up_pulse: assert property (@(posedge clk) disable iff (rst) (up != '0) |=> (up == '0));

endmodule

// File: fm_reg_bank.sv
`timescale 1ns/1ps

module fm_reg_bank (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               clk_en,
	input  logic [fm_reg_pkg::NUM_CLASSES-1:0] up,
	input  logic [fm_slot_pkg::CH_W-1:0]       up_ch,
	input  logic [fm_slot_pkg::OP_W-1:0]       up_op,
	input  fm_reg_pkg::reg_data_u              up_data,
	output logic                               busy,
	output logic                               zero,
	output logic [fm_slot_pkg::CH_W-1:0]       slot_ch,
	output logic [fm_slot_pkg::OP_W-1:0]       slot_op,
	output logic [fm_slot_pkg::FNUM_W-1:0]     fnum,
	output logic [fm_slot_pkg::BLOCK_W-1:0]    block,
	output logic [fm_slot_pkg::MUL_W-1:0]      mul,
	output logic [fm_slot_pkg::TL_W-1:0]       tl,
	output logic                               key,
	output logic [2:0]                         fb,
	output logic [2:0]                         alg,
	output logic [1:0]                         rl
);
	import fm_slot_pkg::*;
	import fm_reg_pkg::*;

	logic [CH_W-1:0]        cur_ch;
	logic [CH_W-1:0]        nxt_ch;
	logic [CH_W-1:0]        prev_ch;
	logic [CH_W-1:0]        tgt_ch;
	logic [CH_W-1:0]        kon_ch;
	logic [OP_W-1:0]        cur_op;
	logic [OP_W-1:0]        nxt_op;
	logic [OP_W-1:0]        prev_op;
	logic [OP_W-1:0]        tgt_op;
	logic [NUM_CLASSES-1:0] pend_cls;
	reg_data_u              pend_data;
	logic                   capture;
	logic                   slot_hit;
	logic                   ch_hit;
	logic                   ch_cls;
	logic                   done;
	logic                   wr_mul;
	logic                   wr_tl;
	logic                   wr_key;
	logic                   wr_fnlo;
	logic                   wr_fnhi;
	logic                   wr_fbalg;
	logic                   wr_pan;

	assign nxt_ch = next_ch(cur_ch);
	assign nxt_op = next_op(cur_ch, cur_op);
	assign slot_ch = cur_ch;
	assign slot_op = cur_op;

	always_ff @(posedge clk) begin
		if (rst) begin
			cur_ch <= '0;
			cur_op <= '0;
			prev_ch <= LAST_CH;
			prev_op <= '1;
			zero <= 1'b1;
		end else if (clk_en) begin
			prev_ch <= cur_ch;
			prev_op <= cur_op;
			cur_ch <= nxt_ch;
			cur_op <= nxt_op;
			zero <= (nxt_ch == '0) && (nxt_op == '0);
		end
	end

	// pending write and busy
	assign capture = (up != '0) && !busy;
	assign slot_hit = (cur_ch == tgt_ch) && (cur_op == tgt_op);
	assign ch_hit = cur_ch == tgt_ch;
	assign ch_cls = pend_cls[FNLO] | pend_cls[FNHI] | pend_cls[FBALG] | pend_cls[PAN];
	assign done = clk_en && busy && (ch_cls ? ch_hit : slot_hit);

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			pend_cls <= '0;
		end else if (capture) begin
			busy <= 1'b1;
			pend_cls <= up;
		end else if (done) begin
			busy <= 1'b0;
			pend_cls <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			pend_data <= up_data;
			kon_ch <= up_ch;
			if (up[KEYON]) begin
				// key-on sweeps a whole revolution and ends on the last slot seen
				tgt_ch <= clk_en ? cur_ch : prev_ch;
				tgt_op <= clk_en ? cur_op : prev_op;
			end else begin
				tgt_ch <= up_ch;
				tgt_op <= up_op;
			end
		end
	end

	assign wr_mul = pend_cls[MUL] && slot_hit;
	assign wr_tl = pend_cls[TL] && slot_hit;
	assign wr_key = pend_cls[KEYON] && (cur_ch == kon_ch);
	assign wr_fnlo = pend_cls[FNLO] && ch_hit;
	assign wr_fnhi = pend_cls[FNHI] && ch_hit;
	assign wr_fbalg = pend_cls[FBALG] && ch_hit;
	assign wr_pan = pend_cls[PAN] && ch_hit;

	// operator memory, written at the current slot and read at the next
	logic [OP_WORD_W-1:0] op_mem [NUM_SLOTS];
	logic [OP_WORD_W-1:0] op_wdata;

	assign op_wdata = {
		wr_key ? pend_data.op_view.kon.mask[cur_op] : key,
		wr_mul ? pend_data.op_view.mult.mul : mul,
		wr_tl ? pend_data.op_view.lvl.tl : tl
	};

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_SLOTS; i++) begin
				op_mem[i] <= '0;
			end
			{key, mul, tl} <= '0;
		end else if (clk_en) begin
			op_mem[slot_idx(cur_ch, cur_op)] <= op_wdata;
			{key, mul, tl} <= op_mem[slot_idx(nxt_ch, nxt_op)];
		end
	end

	// channel words circulate, the last stage belongs to the current channel
	logic [CH_WORD_W-1:0] ch_sh [NUM_CH];
	logic [CH_WORD_W-1:0] ch_wdata;
	logic [BLOCK_W-1:0]   lat_blk;
	logic [FNUM_W-9:0]    lat_fhi;
	logic [7:0]           fnlo_in;

	assign fnlo_in = pend_data;
	assign {lat_blk, lat_fhi, block, fnum, fb, alg, rl} = ch_sh[NUM_CH-1];

	// block and fnum high wait in the latch for the low byte
	assign ch_wdata = {
		wr_fnhi ? {pend_data.ch_view.fhi.block, pend_data.ch_view.fhi.fnhi}
			: {lat_blk, lat_fhi},
		wr_fnlo ? {lat_blk, lat_fhi, fnlo_in} : {block, fnum},
		wr_fbalg ? {pend_data.ch_view.fba.fb, pend_data.ch_view.fba.alg} : {fb, alg},
		wr_pan ? pend_data.ch_view.pan.rl : rl
	};

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_CH; i++) begin
				// both outputs on
				ch_sh[i] <= {{(CH_WORD_W - 2){1'b0}}, 2'b11};
			end
		end else if (clk_en) begin
			ch_sh[0] <= ch_wdata;
			for (int i = 1; i < NUM_CH; i++) begin
				ch_sh[i] <= ch_sh[i-1];
			end
		end
	end

	a_busy_pend: assert property (@(posedge clk) disable iff (rst) busy |-> $onehot(pend_cls));
	a_no_ch37: assert property (@(posedge clk) disable iff (rst) cur_ch[1:0] != 2'b11);

endmodule

// File: fm_phase_step.sv
`timescale 1ns/1ps

module fm_phase_step (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            clk_en,
	input  logic [fm_slot_pkg::CH_W-1:0]    slot_ch,
	input  logic [fm_slot_pkg::OP_W-1:0]    slot_op,
	input  logic [fm_slot_pkg::FNUM_W-1:0]  fnum,
	input  logic [fm_slot_pkg::BLOCK_W-1:0] block,
	input  logic [fm_slot_pkg::MUL_W-1:0]   mul,
	input  logic [fm_slot_pkg::TL_W-1:0]    tl,
	input  logic                            key,
	output logic [fm_slot_pkg::PHASE_W-1:0] phase,
	output logic [fm_slot_pkg::CH_W-1:0]    phase_ch,
	output logic [fm_slot_pkg::OP_W-1:0]    phase_op,
	output logic [fm_slot_pkg::TL_W-1:0]    out_tl,
	output logic                            out_key
);
	import fm_slot_pkg::*;

	logic [PHASE_W-1:0] acc [NUM_SLOTS];
	logic [PHASE_W-1:0] base;
	logic [PHASE_W-1:0] inc;
	logic [PHASE_W-1:0] sum;
	logic [SLOT_W-1:0]  idx;

	assign idx = slot_idx(slot_ch, slot_op);

	always_comb begin
		base = ({{(PHASE_W - FNUM_W){1'b0}}, fnum} << block) >> 1;
		// mul 0 is x0.5
		if (mul == '0) begin
			inc = base >> 1;
		end else begin
			inc = base * PHASE_W'(mul);
		end
	end

	// keyed-off slots stay at zero
	assign sum = key ? acc[idx] + inc : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_SLOTS; i++) begin
				acc[i] <= '0;
			end
			phase <= '0;
			// slot just before channel 0 operator 0
			phase_ch <= LAST_CH;
			phase_op <= '1;
			out_tl <= '0;
			out_key <= 1'b0;
		end else if (clk_en) begin
			acc[idx] <= sum;
			phase <= sum;
			phase_ch <= slot_ch;
			phase_op <= slot_op;
			out_tl <= tl;
			out_key <= key;
		end
	end

	// the sequencer presents the successor of the slot at the output
	a_slot_order: assert property (@(posedge clk) disable iff (rst)
		clk_en |-> (slot_ch == next_ch(phase_ch)) && (slot_op == next_op(phase_ch, phase_op)));

endmodule

// File: fm_regs_top.sv
`timescale 1ns/1ps

module fm_regs_top (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            clk_en,
	input  logic                            wr,
	input  logic                            part,
	input  logic [7:0]                      addr,
	input  logic [7:0]                      din,
	output logic                            busy,
	output logic                            zero,
	output logic [2:0]                      fb,
	output logic [2:0]                      alg,
	output logic [1:0]                      rl,
	output logic [fm_slot_pkg::PHASE_W-1:0] phase,
	output logic [fm_slot_pkg::CH_W-1:0]    phase_ch,
	output logic [fm_slot_pkg::OP_W-1:0]    phase_op,
	output logic [fm_slot_pkg::TL_W-1:0]    out_tl,
	output logic                            out_key
);
	import fm_slot_pkg::*;
	import fm_reg_pkg::*;

	// decoder to bank
	logic [NUM_CLASSES-1:0] up;
	logic [CH_W-1:0]        up_ch;
	logic [OP_W-1:0]        up_op;
	reg_data_u              up_data;

	// bank to phase stepper
	logic [CH_W-1:0]        slot_ch;
	logic [OP_W-1:0]        slot_op;
	logic [FNUM_W-1:0]      fnum;
	logic [BLOCK_W-1:0]     block;
	logic [MUL_W-1:0]       mul;
	logic [TL_W-1:0]        tl;
	logic                   key;

	fm_write_decoder fm_write_decoder_inst (
		.clk     (clk),
		.rst     (rst),
		.wr      (wr),
		.part    (part),
		.addr    (addr),
		.din     (din),
		.busy    (busy),
		.up      (up),
		.up_ch   (up_ch),
		.up_op   (up_op),
		.up_data (up_data)
	);

	fm_reg_bank fm_reg_bank_inst (
		.clk     (clk),
		.rst     (rst),
		.clk_en  (clk_en),
		.up      (up),
		.up_ch   (up_ch),
		.up_op   (up_op),
		.up_data (up_data),
		.busy    (busy),
		.zero    (zero),
		.slot_ch (slot_ch),
		.slot_op (slot_op),
		.fnum    (fnum),
		.block   (block),
		.mul     (mul),
		.tl      (tl),
		.key     (key),
		.fb      (fb),
		.alg     (alg),
		.rl      (rl)
	);

	fm_phase_step fm_phase_step_inst (
		.clk      (clk),
		.rst      (rst),
		.clk_en   (clk_en),
		.slot_ch  (slot_ch),
		.slot_op  (slot_op),
		.fnum     (fnum),
		.block    (block),
		.mul      (mul),
		.tl       (tl),
		.key      (key),
		.phase    (phase),
		.phase_ch (phase_ch),
		.phase_op (phase_op),
		.out_tl   (out_tl),
		.out_key  (out_key)
	);

endmodule

// File: tb_fm_regs.sv
`timescale 1ns/1ps

module tb_fm_regs;
	import fm_slot_pkg::*;
	import fm_reg_pkg::*;

	localparam int N_WR = 40;
	localparam int OBS_CYCLES = 600;
	localparam longint WD_NS = (N_WR * 2 * NUM_SLOTS + OBS_CYCLES) * 8 * 4;

	logic               clk;
	logic               rst;
	logic               clk_en;
	logic               wr;
	logic               part;
	logic [7:0]         addr;
	logic [7:0]         din;
	logic               busy;
	logic               zero;
	logic [2:0]         fb;
	logic [2:0]         alg;
	logic [1:0]         rl;
	logic [PHASE_W-1:0] phase;
	logic [CH_W-1:0]    phase_ch;
	logic [OP_W-1:0]    phase_op;
	logic [TL_W-1:0]    out_tl;
	logic               out_key;

	// model state by channel position 0..5 and by slot op * 6 + position
	logic [10:0] m_fnum [6];
	logic [2:0]  m_blk [6];
	logic [2:0]  m_lblk [6];
	logic [2:0]  m_lfhi [6];
	logic [2:0]  m_fb [6];
	logic [2:0]  m_alg [6];
	logic [1:0]  m_rl [6];
	logic [3:0]  m_mul [24];
	logic [6:0]  m_tl [24];
	logic        m_key [24];

	logic [PHASE_W-1:0] prev_ph [24];
	bit                 known [24];
	bit                 arm_val;
	bit                 arm_inc;
	int                 exp_k;
	int                 err_cnt;
	int                 chk_cnt;
	int                 test_cnt;

	fm_regs_top fm_regs_top_inst (
		.clk      (clk),
		.rst      (rst),
		.clk_en   (clk_en),
		.wr       (wr),
		.part     (part),
		.addr     (addr),
		.din      (din),
		.busy     (busy),
		.zero     (zero),
		.fb       (fb),
		.alg      (alg),
		.rl       (rl),
		.phase    (phase),
		.phase_ch (phase_ch),
		.phase_op (phase_op),
		.out_tl   (out_tl),
		.out_key  (out_key)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	initial begin
		#(WD_NS);
		$display("timeout: the run did not finish in time");
		$display("Some tests failed");
		$finish;
	end

	// channel codes skip 3
	function automatic int ch_code(input int p);
		return (p < 3) ? p : p + 1;
	endfunction

	function automatic logic [PHASE_W-1:0] calc_inc(input int k);
		logic [PHASE_W-1:0] b;
		int p;
		p = k % 6;
		b = (PHASE_W'(m_fnum[p]) << m_blk[p]) >> 1;
		if (m_mul[k] == 0) begin
			return b >> 1;
		end
		return b * PHASE_W'(m_mul[k]);
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("error %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// slot visits and channel outputs sampled at the falling edge
	initial begin
		bit en;
		bit r;
		int k;
		logic [PHASE_W-1:0] e;
		forever begin
			@(posedge clk);
			en = clk_en;
			r = rst;
			@(negedge clk);
			if (r) begin
				exp_k = 0;
			end else begin
				if (en) begin
					k = exp_k;
					check("phase_ch", phase_ch, ch_code(k % 6));
					check("phase_op", phase_op, k / 6);
					if (!out_key) begin
						check("phase", phase, 0);
					end else if (arm_inc && known[k]) begin
						e = prev_ph[k] + calc_inc(k);
						check("phase", phase, e);
					end
					if (arm_val) begin
						check("out_tl", out_tl, m_tl[k]);
						check("out_key", out_key, m_key[k]);
					end
					prev_ph[k] = phase;
					known[k] = arm_inc;
					exp_k = (k + 1) % NUM_SLOTS;
				end
				check("zero", zero, exp_k == 0);
				if (arm_val) begin
					check("fb", fb, m_fb[exp_k % 6]);
					check("alg", alg, m_alg[exp_k % 6]);
					check("rl", rl, m_rl[exp_k % 6]);
				end
			end
		end
	end

	task automatic wait_en(input int n);
		int c;
		c = 0;
		while (c < n) begin
			@(posedge clk);
			if (clk_en) begin
				c++;
			end
		end
		#1;
	endtask

	task automatic settle(input bit clear);
		wait_en(2);
		if (clear) begin
			foreach (known[i]) begin
				known[i] = 0;
			end
		end
		arm_val = 1;
		arm_inc = 1;
	endtask

	task automatic host_write(input bit p, input logic [7:0] a, input logic [7:0] d,
		input bit mapped);
		int n;
		@(posedge clk);
		#1;
		wr = 1'b1;
		part = p;
		addr = a;
		din = d;
		@(posedge clk);
		#1;
		wr = 1'b0;
		if (mapped) begin
			@(posedge clk);
			#1;
			check("busy", busy, 1);
			n = 0;
			while (busy && n <= NUM_SLOTS) begin
				@(posedge clk);
				if (clk_en) begin
					n++;
				end
				#1;
			end
			if (busy || n > NUM_SLOTS) begin
				err_cnt++;
				$display("busy stayed high for more than one revolution at %0t", $time);
			end
		end else begin
			repeat (4) begin
				@(posedge clk);
				#1;
				check("busy", busy, 0);
			end
		end
	endtask

	task automatic set_tl(input int p, input int o, input logic [6:0] v);
		arm_val = 0;
		host_write(p >= 3, ADDR_TL + 8'(o * 4 + p % 3), {1'b0, v}, 1);
		m_tl[o * 6 + p] = v;
		settle(0);
	endtask

	task automatic set_mul(input int p, input int o, input logic [3:0] v);
		arm_val = 0;
		arm_inc = 0;
		host_write(p >= 3, ADDR_MUL + 8'(o * 4 + p % 3), {4'h0, v}, 1);
		m_mul[o * 6 + p] = v;
		settle(1);
	endtask

	task automatic set_fbalg(input int p, input logic [2:0] f, input logic [2:0] a);
		arm_val = 0;
		host_write(p >= 3, ADDR_FBALG + 8'(p % 3), {2'b00, f, a}, 1);
		m_fb[p] = f;
		m_alg[p] = a;
		settle(0);
	endtask

	task automatic set_pan(input int p, input logic [1:0] v);
		arm_val = 0;
		host_write(p >= 3, ADDR_PAN + 8'(p % 3), {v, 6'h00}, 1);
		m_rl[p] = v;
		settle(0);
	endtask

	// block and high bits only reach the latch
	task automatic set_fnhi(input int p, input logic [2:0] b, input logic [2:0] h);
		arm_val = 0;
		host_write(p >= 3, ADDR_FNHI + 8'(p % 3), {2'b00, b, h}, 1);
		m_lblk[p] = b;
		m_lfhi[p] = h;
		settle(0);
	endtask

	task automatic set_fnlo(input int p, input logic [7:0] v);
		arm_val = 0;
		arm_inc = 0;
		host_write(p >= 3, ADDR_FNLO + 8'(p % 3), v, 1);
		m_fnum[p] = {m_lfhi[p], v};
		m_blk[p] = m_lblk[p];
		settle(1);
	endtask

	task automatic set_keyon(input int p, input logic [3:0] mask);
		arm_val = 0;
		host_write(0, ADDR_KEYON, {mask, 1'b0, 3'(ch_code(p))}, 1);
		for (int o = 0; o < 4; o++) begin
			m_key[o * 6 + p] = mask[o];
		end
		settle(0);
	endtask

	task automatic report(input string name, input int err_before);
		test_cnt++;
		if (err_cnt == err_before) begin
			$display("test %0d %s: ok", test_cnt, name);
		end else begin
			$display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_before);
		end
	endtask

	initial begin
		int e0;
		int p;
		logic [7:0] bad [8];
		bad = '{8'h10, 8'h20, 8'h27, 8'h29, 8'h43, 8'hA8, 8'hB8, 8'hFF};
		void'($urandom(58));
		rst = 1'b1;
		clk_en = 1'b0;
		wr = 1'b0;
		part = 1'b0;
		addr = '0;
		din = '0;
		err_cnt = 0;
		chk_cnt = 0;
		test_cnt = 0;
		arm_val = 0;
		arm_inc = 0;
		for (int i = 0; i < 6; i++) begin
			{m_fnum[i], m_blk[i], m_lblk[i], m_lfhi[i], m_fb[i], m_alg[i]} = '0;
			m_rl[i] = 2'b11;
		end
		for (int i = 0; i < 24; i++) begin
			{m_mul[i], m_tl[i], m_key[i]} = '0;
			known[i] = 0;
		end
		// random clock enable on about three clocks in four
		fork
			forever begin
				@(posedge clk);
				#1;
				clk_en = ($urandom % 4) != 0;
			end
		join_none
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;

		e0 = err_cnt;
		@(negedge clk);
		check("busy", busy, 0);
		check("rl", rl, 2'b11);
		check("phase", phase, 0);
		arm_val = 1;
		arm_inc = 1;
		wait_en(48);
		report("reset and order", e0);

		e0 = err_cnt;
		repeat (8) begin
			p = $urandom % 6;
			case ($urandom % 3)
				0: set_tl(p, $urandom % 4, $urandom);
				1: set_fbalg(p, $urandom, $urandom);
				default: set_pan(p, $urandom);
			endcase
		end
		wait_en(24);
		report("register readback", e0);

		e0 = err_cnt;
		for (int i = 0; i < 6; i++) begin
			set_keyon(i, 4'hF);
		end
		repeat (2) begin
			p = $urandom % 6;
			set_fnhi(p, $urandom, $urandom);
			wait_en(48);
			set_fnlo(p, $urandom);
			wait_en(48);
		end
		report("frequency latch", e0);

		e0 = err_cnt;
		repeat (3) begin
			p = $urandom % 6;
			set_fnhi(p, $urandom, $urandom);
			set_fnlo(p, $urandom);
		end
		repeat (6) begin
			set_mul($urandom % 6, $urandom % 4, $urandom);
		end
		wait_en(48);
		report("phase increments", e0);

		e0 = err_cnt;
		p = $urandom % 6;
		set_keyon(p, 4'h0);
		wait_en(24);
		set_keyon(p, 4'(1 + $urandom % 15));
		wait_en(24);
		report("key-on and key-off", e0);

		e0 = err_cnt;
		repeat (6) begin
			if ($urandom % 4 == 0) begin
				// key-on naming channel code 3
				host_write($urandom, ADDR_KEYON, {4'($urandom), 4'h3}, 0);
			end else begin
				host_write($urandom, bad[$urandom % 8], $urandom, 0);
			end
		end
		wait_en(24);
		report("unmapped addresses", e0);

		$display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: fm_regs.f
fm_slot_pkg.sv
fm_reg_pkg.sv
fm_write_decoder.sv
fm_reg_bank.sv
fm_phase_step.sv
fm_regs_top.sv
tb_fm_regs.sv

// File: Bender.yml
package:
  name: fm_regs

sources:
  - fm_slot_pkg.sv
  - fm_reg_pkg.sv
  - fm_write_decoder.sv
  - fm_reg_bank.sv
  - fm_phase_step.sv
  - fm_regs_top.sv
  - target: test
    files:
      - tb_fm_regs.sv
